// File: src/isaPkg.sv
package isaPkg;

    typedef enum logic [3:0] {
        OP_MOV  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_MUL  = 4'd3,
        OP_IN   = 4'd7,
        OP_OUT  = 4'd8,
        OP_STOP = 4'd15
    } opcode_e;

    typedef struct packed {
        logic       ind;   // Word at addr is a pointer
        logic [2:0] addr;
    } operand_t;

    typedef struct packed {
        opcode_e  op;
        operand_t f1;      // Destination of every writing instruction
        operand_t f2;
        operand_t f3;
    } instr_t;

    localparam logic [3:0] IMM_MARK = 4'd8;
    localparam logic [5:0] START_PC = 6'd8;

    typedef enum logic [3:0] {
        ST_RESET,
        ST_FETCH0,
        ST_FETCH1,
        ST_FETCH2,
        ST_OPER,
        ST_IND,
        ST_EXEC,
        ST_DSTIND,
        ST_WRITE,
        ST_HALT
    } ctrlState_e;

    function automatic logic isArith(opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_MUL};
    endfunction

    // MOV carrying a second word as its source
    function automatic logic isImmMov(instr_t ir);
        return (ir.op == OP_MOV) && (ir.f3 == IMM_MARK);
    endfunction

endpackage

// File: src/busPkg.sv
package busPkg;

    localparam int ADDR_W = 6;
    localparam int DATA_W = 16;

    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } memReq_t;

    typedef enum logic [1:0] {
        MAR_PC,
        MAR_FIELD,
        MAR_PTR
    } marSel_e;

    typedef enum logic [1:0] {
        ACC_MEM,
        ACC_IN,
        ACC_ALU,
        ACC_IMM
    } accSel_e;

    typedef struct packed {
        logic    ldPc;
        logic    incPc;
        logic    ldIrHi;
        logic    ldIrLo;
        logic    ldMar;
        logic    ldAcc;
        logic    ldOpB;
        logic    ldWdata;
        logic    ldOut;
        marSel_e marSel;
        accSel_e accSel;
        logic [1:0] opSel;   // Instruction field number 1..3 for MAR_FIELD
    } dpCtrl_t;

endpackage

// File: src/datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter int DATA_W = busPkg::DATA_W
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  busPkg::dpCtrl_t           dpCtrl,
    input  logic [DATA_W-1:0]         memRdata,
    input  logic [DATA_W-1:0]         inData,
    output isaPkg::instr_t            instr,
    output logic [busPkg::ADDR_W-1:0] memAddr,
    output logic [DATA_W-1:0]         memWdata,
    output logic [DATA_W-1:0]         outData
);
    import isaPkg::*;
    import busPkg::*;

    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] irLo;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] opB;
    logic [DATA_W-1:0] aluRes;
    logic [DATA_W-1:0] accIn;
    logic [ADDR_W-1:0] fieldAddr;
    logic [ADDR_W-1:0] marIn;

    // Operand addresses only reach the low eight words
    always_comb begin
        case (dpCtrl.opSel)
            2'd1:    fieldAddr = ADDR_W'(instr.f1.addr);
            2'd2:    fieldAddr = ADDR_W'(instr.f2.addr);
            default: fieldAddr = ADDR_W'(instr.f3.addr);
        endcase
    end

    always_comb begin
        case (dpCtrl.marSel)
            MAR_FIELD: marIn = fieldAddr;
            MAR_PTR:   marIn = memRdata[ADDR_W-1:0];
            default:   marIn = pc;
        endcase
    end

    always_comb begin
        case (instr.op)
            OP_ADD:  aluRes = acc + opB;
            OP_SUB:  aluRes = acc - opB;
            OP_MUL:  aluRes = acc * opB;   // Low half kept
            default: aluRes = acc;
        endcase
    end

    always_comb begin
        case (dpCtrl.accSel)
            ACC_IN:  accIn = inData;
            ACC_ALU: accIn = aluRes;
            ACC_IMM: accIn = irLo;
            default: accIn = memRdata;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= START_PC;
            memAddr <= START_PC;
            instr   <= '0;
            outData <= '0;
        end else begin
            if (dpCtrl.ldPc) begin
                pc <= START_PC;
            end else if (dpCtrl.incPc) begin
                pc <= pc + ADDR_W'(1);
            end
            if (dpCtrl.ldMar) begin
                memAddr <= marIn;
            end
            if (dpCtrl.ldIrHi) begin
                instr <= instr_t'(memRdata[$bits(instr_t)-1:0]);
            end
            if (dpCtrl.ldOut) begin
                outData <= acc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dpCtrl.ldIrLo) begin
            irLo <= memRdata;
        end
        if (dpCtrl.ldAcc) begin
            acc <= accIn;
        end
        if (dpCtrl.ldOpB) begin
            opB <= memRdata;
        end
        // Written word follows the same source as the accumulator
        if (dpCtrl.ldWdata) begin
            memWdata <= accIn;
        end
    end

endmodule

// File: src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit #(
    parameter int DATA_W = busPkg::DATA_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  isaPkg::instr_t    instr,
    input  logic [DATA_W-1:0] memRdata,
    output busPkg::dpCtrl_t   dpCtrl,
    output logic              memWe,
    output logic              outStrobe,
    output logic              halted
);
    import isaPkg::*;
    import busPkg::*;

    ctrlState_e state;
    ctrlState_e stateNext;
    logic [1:0] opCnt;       // Source operands addressed so far
    logic [1:0] opCntNext;
    logic [1:0] numOps;
    logic [1:0] fieldNum;
    logic       knownOp;
    operand_t   curField;
    instr_t     fetched;

    // Instruction word still on the bus during FETCH1
    assign fetched = instr_t'(memRdata[$bits(instr_t)-1:0]);

    always_comb begin
        if (isArith(instr.op)) begin
            numOps = 2'd2;
        end else if (instr.op == OP_OUT || (instr.op == OP_MOV && !isImmMov(instr))) begin
            numOps = 2'd1;
        end else begin
            numOps = 2'd0;
        end
    end

    assign knownOp = (numOps != 2'd0) || (instr.op == OP_MOV) || (instr.op == OP_IN);

    always_comb begin
        if (instr.op == OP_OUT) begin
            fieldNum = 2'd1;
        end else if (opCnt == 2'd1) begin
            fieldNum = 2'd3;   // Second arithmetic source
        end else begin
            fieldNum = 2'd2;
        end
    end

    always_comb begin
        case (fieldNum)
            2'd1:    curField = instr.f1;
            2'd3:    curField = instr.f3;
            default: curField = instr.f2;
        endcase
    end

    always_comb begin
        dpCtrl    = '0;
        stateNext = state;
        opCntNext = opCnt;
        case (state)
            ST_RESET: begin
                dpCtrl.ldPc = 1'b1;
                stateNext   = ST_FETCH0;
            end
            ST_FETCH0: begin
                dpCtrl.ldMar  = 1'b1;
                dpCtrl.marSel = MAR_PC;
                dpCtrl.incPc  = 1'b1;
                stateNext     = ST_FETCH1;
            end
            ST_FETCH1: begin
                dpCtrl.ldIrHi = 1'b1;
                if (isImmMov(fetched)) begin
                    dpCtrl.ldMar  = 1'b1;
                    dpCtrl.marSel = MAR_PC;
                    dpCtrl.incPc  = 1'b1;
                    stateNext     = ST_FETCH2;
                end else begin
                    stateNext = ST_OPER;
                end
            end
            ST_FETCH2: begin
                dpCtrl.ldIrLo = 1'b1;
                stateNext     = ST_OPER;
            end
            ST_OPER: begin
                // Capture the operand addressed on the previous pass
                dpCtrl.accSel = ACC_MEM;
                dpCtrl.ldAcc  = (opCnt == 2'd1);
                dpCtrl.ldOpB  = (opCnt == 2'd2);
                if (opCnt != numOps) begin
                    dpCtrl.ldMar  = 1'b1;
                    dpCtrl.marSel = MAR_FIELD;
                    dpCtrl.opSel  = fieldNum;
                    opCntNext     = opCnt + 2'd1;
                    stateNext     = curField.ind ? ST_IND : ST_OPER;
                end else begin
                    opCntNext = 2'd0;
                    if (instr.op == OP_STOP) begin
                        stateNext = ST_HALT;
                    end else if (knownOp) begin
                        stateNext = ST_EXEC;
                    end else begin
                        stateNext = ST_FETCH0;   // Unused opcode acts as no-op
                    end
                end
            end
            ST_IND: begin
                dpCtrl.ldMar  = 1'b1;
                dpCtrl.marSel = MAR_PTR;
                stateNext     = ST_OPER;
            end
            ST_EXEC: begin
                if (instr.op == OP_OUT) begin
                    dpCtrl.ldOut = 1'b1;
                    stateNext    = ST_FETCH0;
                end else begin
                    dpCtrl.ldAcc   = 1'b1;
                    dpCtrl.ldWdata = 1'b1;
                    dpCtrl.ldMar   = 1'b1;
                    dpCtrl.marSel  = MAR_FIELD;
                    dpCtrl.opSel   = 2'd1;
                    stateNext      = instr.f1.ind ? ST_DSTIND : ST_WRITE;
                    if (isArith(instr.op)) begin
                        dpCtrl.accSel = ACC_ALU;
                    end else if (instr.op == OP_IN) begin
                        dpCtrl.accSel = ACC_IN;
                    end else if (isImmMov(instr)) begin
                        dpCtrl.accSel = ACC_IMM;
                    end else begin
                        dpCtrl.accSel = ACC_MEM;   // MAR still on the MOV source
                    end
                end
            end
            ST_DSTIND: begin
                dpCtrl.ldMar  = 1'b1;
                dpCtrl.marSel = MAR_PTR;
                stateNext     = ST_WRITE;
            end
            ST_WRITE: stateNext = ST_FETCH0;
            ST_HALT:  stateNext = ST_HALT;
            default:  stateNext = ST_RESET;
        endcase
    end

    assign memWe  = (state == ST_WRITE);
    assign halted = (state == ST_HALT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_RESET;
            opCnt     <= 2'd0;
            outStrobe <= 1'b0;
        end else begin
            state     <= stateNext;
            opCnt     <= opCntNext;
            outStrobe <= dpCtrl.ldOut;   // High while outData shows the new value
        end
    end

endmodule

// File: src/accCpu.sv
`timescale 1ns/1ps

module accCpu #(
    parameter int DATA_W = busPkg::DATA_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] memRdata,
    input  logic [DATA_W-1:0] inData,
    output busPkg::memReq_t   memReq,
    output logic [DATA_W-1:0] outData,
    output logic              outStrobe,
    output logic              halted
);
    import isaPkg::*;
    import busPkg::*;

    dpCtrl_t           dpCtrl;
    instr_t            instr;
    logic              memWe;
    logic [ADDR_W-1:0] memAddr;
    logic [DATA_W-1:0] memWdata;

    controlUnit #(
        .DATA_W(DATA_W)
    ) controlUnit_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .memRdata (memRdata),
        .dpCtrl   (dpCtrl),
        .memWe    (memWe),
        .outStrobe(outStrobe),
        .halted   (halted)
    );

    datapath #(
        .DATA_W(DATA_W)
    ) datapath_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .dpCtrl  (dpCtrl),
        .memRdata(memRdata),
        .inData  (inData),
        .instr   (instr),
        .memAddr (memAddr),
        .memWdata(memWdata),
        .outData (outData)
    );

    // Strobe from control, address and data from datapath registers
    assign memReq = '{we: memWe, addr: memAddr, wdata: memWdata};

endmodule

// File: bench/accCpuAssertions.sv
`timescale 1ns/1ps

module accCpuAssertions (
    input logic            clk,
    input logic            rst_n,
    input busPkg::memReq_t memReq,
    input logic            outStrobe,
    input logic            halted
);

    // No memory traffic once stopped
    noWriteWhileHalted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !memReq.we)
        else $error("Write strobe high while halted");

    haltHeld: assert property (@(posedge clk) disable iff (!rst_n)
        $past(halted) |-> halted)
        else $error("halted fell without a reset");

    strobePulse: assert property (@(posedge clk) disable iff (!rst_n)
        $past(outStrobe) |-> !outStrobe)
        else $error("outStrobe stayed high for more than one cycle");

endmodule

bind accCpu accCpuAssertions accCpuAssertions_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .memReq   (memReq),
    .outStrobe(outStrobe),
    .halted   (halted)
);

// File: bench/accCpuTb.sv
`timescale 1ns/1ps

module accCpuTb;
    import isaPkg::*;
    import busPkg::*;

    localparam int HALT_TIMEOUT = 200;
    localparam int HALT_SETTLE  = 20;

    typedef struct packed {
        logic [3:0]  op;
        logic        imm;        // MOV with a second word
        logic [2:0]  ind;        // Indirect flags of fields 1, 2, 3
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] inVal;
        logic [15:0] expected;
    } row_t;

    logic              clk;
    logic              rst_n;
    logic              loadMem;
    logic [DATA_W-1:0] inData;
    logic [DATA_W-1:0] memRdata;
    logic [DATA_W-1:0] outData;
    logic              outStrobe;
    logic              halted;
    memReq_t           memReq;

    logic [15:0] mem [64];
    logic [15:0] img [64];
    logic [15:0] expImg [64];
    logic        expWrites;
    logic [15:0] lastOut;
    logic [31:0] rngState;
    row_t        rows [$];
    int          writeCount;
    int          strobeCount;
    int          curRow;
    int          checks;
    int          valueErrors;
    int          timeouts;

    accCpu #(
        .DATA_W(DATA_W)
    ) accCpu_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .memRdata (memRdata),
        .inData   (inData),
        .memReq   (memReq),
        .outData  (outData),
        .outStrobe(outStrobe),
        .halted   (halted)
    );

    always #20 clk = ~clk;

    // Combinational read, write on the rising edge
    assign memRdata = mem[memReq.addr];

    always @(posedge clk) begin
        if (loadMem) begin
            mem <= img;
        end else if (memReq.we) begin
            mem[memReq.addr] <= memReq.wdata;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            writeCount  <= 0;
            strobeCount <= 0;
            lastOut     <= '0;
        end else begin
            if (memReq.we) begin
                writeCount <= writeCount + 1;
            end
            if (outStrobe) begin
                strobeCount <= strobeCount + 1;
                lastOut     <= outData;
            end
        end
    end

    function automatic logic [31:0] nextRandom(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] randWord();
        rngState = nextRandom(rngState);
        return rngState[15:0];
    endfunction

    function automatic logic [15:0] fillWord(int a);
        return 16'hC000 + 16'(a) * 16'h0111;
    endfunction

    function automatic logic writesDest(logic [3:0] op);
        return op inside {OP_MOV, OP_ADD, OP_SUB, OP_MUL, OP_IN};
    endfunction

    // Results wrap to 16 bits
    function automatic logic [15:0] resultFor(logic [3:0] op, logic [15:0] a, logic [15:0] b,
                                              logic [15:0] inVal);
        logic [16:0] sum;
        logic [16:0] diff;
        logic [31:0] prod;
        sum  = 17'(a) + 17'(b);
        diff = 17'(a) - 17'(b);
        prod = 32'(a) * 32'(b);
        case (op)
            OP_MOV:  return a;
            OP_ADD:  return sum[15:0];
            OP_SUB:  return diff[15:0];
            OP_MUL:  return prod[15:0];
            OP_IN:   return inVal;
            default: return fillWord(3);   // No-op leaves the destination word alone
        endcase
    endfunction

    task automatic addRow(input logic [3:0] op, input logic imm, input logic [2:0] ind,
                          input logic [15:0] a, input logic [15:0] b, input logic [15:0] inVal);
        row_t r;
        r.op       = op;
        r.imm      = imm;
        r.ind      = ind;
        r.a        = a;
        r.b        = b;
        r.inVal    = inVal;
        r.expected = resultFor(op, a, b, inVal);
        rows.push_back(r);
    endtask

    task automatic buildTable();
        int k;
        addRow(OP_MOV, 1'b1, 3'b000, 16'hBEEF, 16'h0, 16'h0);
        addRow(OP_MOV, 1'b0, 3'b000, 16'h1234, 16'h0, 16'h0);
        addRow(OP_MOV, 1'b0, 3'b110, 16'h0F0F, 16'h0, 16'h0);
        addRow(OP_MOV, 1'b1, 3'b100, 16'h7E57, 16'h0, 16'h0);
        for (k = 0; k < 8; k++) begin
            addRow(OP_ADD, 1'b0, 3'(k), randWord(), randWord(), 16'h0);
            addRow(OP_SUB, 1'b0, 3'(k), randWord(), randWord(), 16'h0);
            addRow(OP_MUL, 1'b0, 3'(k), randWord(), randWord(), 16'h0);
        end
        addRow(OP_ADD, 1'b0, 3'b000, 16'hFFFF, 16'h0003, 16'h0);   // Carry out dropped
        addRow(OP_SUB, 1'b0, 3'b000, 16'h0001, 16'h0002, 16'h0);
        addRow(OP_MUL, 1'b0, 3'b000, 16'hFFFF, 16'hFFFF, 16'h0);
        addRow(OP_IN, 1'b0, 3'b000, 16'h0, 16'h0, 16'hC3A5);
        addRow(OP_IN, 1'b0, 3'b100, 16'h0, 16'h0, randWord());
        addRow(4'd4, 1'b0, 3'b000, 16'h0, 16'h0, 16'h0);
        addRow(4'd5, 1'b0, 3'b000, 16'h0, 16'h0, 16'h0);
        addRow(4'd9, 1'b0, 3'b000, 16'h0, 16'h0, 16'h0);
        addRow(4'd14, 1'b0, 3'b000, 16'h0, 16'h0, 16'h0);
    endtask

    // Data in words 1..7 and 40..42, program from word 8
    task automatic buildImage(input row_t r);
        logic [3:0] f1;
        logic [3:0] f2;
        logic [3:0] f3;
        int         k;
        int         pc;
        for (k = 0; k < 64; k++) begin
            img[k] = fillWord(k);
        end
        img[4] = 16'd40;   // Pointers
        img[5] = 16'd41;
        img[6] = 16'd42;
        f1 = r.ind[2] ? 4'hE : 4'h3;
        f2 = r.ind[1] ? 4'hC : 4'h1;
        f3 = r.ind[0] ? 4'hD : 4'h2;
        // Immediate value lives only in the second word
        if (!r.imm) begin
            img[r.ind[1] ? 40 : 1] = r.a;
        end
        img[r.ind[0] ? 41 : 2] = r.b;
        if (r.imm) begin
            f3 = IMM_MARK;
        end
        img[8] = {r.op, f1, f2, f3};
        pc = 9;
        if (r.imm) begin
            img[9] = r.a;
            pc     = 10;
        end
        img[pc]     = {OP_OUT, f1, 8'h00};
        img[pc + 1] = {OP_STOP, 12'h000};
        expImg    = img;
        expWrites = writesDest(r.op);
        if (expWrites) begin
            expImg[r.ind[2] ? 42 : 3] = r.expected;
        end
    endtask

    task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: got %h, expected %h (row %0d)", name, got, exp, curRow);
            valueErrors++;
        end
    endtask

    task automatic runRow(input row_t r);
        int n;
        int writesAtHalt;
        buildImage(r);
        inData  = r.inVal;
        rst_n   = 1'b0;
        loadMem = 1'b1;
        @(negedge clk);
        loadMem = 1'b0;
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        checkValue("outData after reset", outData, 16'h0);
        checkValue("{outStrobe,halted,we} after reset", 16'({outStrobe, halted, memReq.we}),
                   16'h0);
        n = 0;
        while (!halted && n < HALT_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (halted) else begin
            $display("Row %0d did not halt within %0d cycles", curRow, HALT_TIMEOUT);
            timeouts++;
        end
        if (halted) begin
            writesAtHalt = writeCount;
            for (n = 0; n < HALT_SETTLE; n++) begin
                @(negedge clk);
            end
            checkValue("writes after halt", 16'(writeCount - writesAtHalt), 16'h0);
            checkValue("write count", 16'(writesAtHalt), 16'(expWrites));
            checkValue("outStrobe count", 16'(strobeCount), 16'h1);
            checkValue("strobed outData", lastOut, r.expected);
            checkValue("outData", outData, r.expected);
            for (n = 0; n < 64; n++) begin
                checkValue($sformatf("mem[%0d]", n), mem[n], expImg[n]);
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        loadMem     = 1'b0;
        inData      = '0;
        rngState    = 32'd51863;
        checks      = 0;
        valueErrors = 0;
        timeouts    = 0;
        buildTable();
        @(negedge clk);
        for (curRow = 0; curRow < rows.size(); curRow++) begin
            runRow(rows[curRow]);
        end
        $display("Summary: %0d rows, %0d checks, %0d value errors, %0d timeouts",
                 rows.size(), checks, valueErrors, timeouts);
        if (valueErrors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: accCpu.f
src/isaPkg.sv
src/busPkg.sv
src/datapath.sv
src/controlUnit.sv
src/accCpu.sv
bench/accCpuAssertions.sv
bench/accCpuTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module accCpuTb -f accCpu.f &&
{ out="$(./obj_dir/VaccCpuTb 2>&1)"; printf '%s\n' "$out"; } &&
printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
